// File: design/shared_ram_pkg.sv
`default_nettype none

package shared_ram_pkg;

    // client count and memory geometry
    localparam int N_CLIENTS = 4;
    localparam int ADDR_W = 6;
    localparam int DATA_W = 16;
    localparam int MEM_DEPTH = 64;

    // one bit per client
    // used for pending, hold, grant, busy and rvalid
    typedef logic [N_CLIENTS-1:0] client_vec_t;

    // word address into the shared memory
    typedef logic [ADDR_W-1:0] addr_t;

    // memory data word
    typedef logic [DATA_W-1:0] data_t;

    // per-client request state
    typedef enum logic {
        // nothing pending
        PORT_IDLE,
        // command held until granted
        PORT_WAIT
    } port_state_t;

endpackage

`default_nettype wire

// File: design/rr_thermo_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module rr_thermo_arbiter
    import shared_ram_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  client_vec_t request,
    input  client_vec_t hold,
    output client_vec_t grant
);

    // pointer mask, ones at and above the first client to consider
    client_vec_t pointer_mask;
    client_vec_t masked_req;
    // thermometer codes, bit i set when any request at or below i
    client_vec_t thermo_all;
    client_vec_t thermo_masked;
    client_vec_t thermo_sel;
    // selected code shifted up one place
    client_vec_t next_mask;
    logic        any_grant;
    logic        grant_held;

    // running OR from bit 0 upward
    function automatic client_vec_t thermo(input client_vec_t v);
        client_vec_t t;
        t[0] = v[0];
        for (int i = 1; i < N_CLIENTS; i++) begin
            t[i] = t[i-1] | v[i];
        end
        return t;
    endfunction

    // requests at or above the pointer
    assign masked_req = request & pointer_mask;

    assign thermo_all = thermo(request);
    assign thermo_masked = thermo(masked_req);

    // top bit of a code says whether it holds any request
    // masked code wins when non-empty, else wrap to the lowest request
    assign thermo_sel = thermo_masked[N_CLIENTS-1] ? thermo_masked : thermo_all;

    // shifted copy has ones strictly above the winner
    assign next_mask = thermo_sel << 1;

    // rising edge of the thermometer is the one-hot winner
    assign grant = thermo_sel ^ next_mask;

    assign any_grant = thermo_all[N_CLIENTS-1];

    // winner asked to keep first place
    assign grant_held = |(grant & hold);

    // pointer moves one past the winner unless the grant is held
    // all-zero mask after the top client wraps to client 0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pointer_mask <= '1;
        end else if (any_grant && !grant_held) begin
            pointer_mask <= next_mask;
        end
    end

endmodule

`default_nettype wire

// File: design/client_port.sv
`timescale 1ns/1ps
`default_nettype none

module client_port
    import shared_ram_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    // client side request levels
    input  logic  req,
    input  logic  we,
    input  logic  hold,
    input  addr_t addr,
    input  data_t wdata,
    // this client's grant bit
    input  logic  granted,
    // pending flag, also the request toward the arbiter
    output logic  busy,
    output logic  pending_hold,
    // held command toward the memory
    output logic  cmd_we,
    output addr_t cmd_addr,
    output data_t cmd_wdata,
    // one-cycle read completion
    output logic  rvalid
);

    port_state_t state;
    logic        accept;

    // pending exactly while waiting
    assign busy = (state == PORT_WAIT);

    // req while busy is dropped
    assign accept = (state == PORT_IDLE) && req;

    // request state, access type and hold flag
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= PORT_IDLE;
            cmd_we <= 1'b0;
            pending_hold <= 1'b0;
            rvalid <= 1'b0;
        end else begin
            // rvalid is a single-cycle pulse
            rvalid <= 1'b0;
            case (state)
                PORT_IDLE: begin
                    if (req) begin
                        state <= PORT_WAIT;
                        cmd_we <= we;
                        pending_hold <= hold;
                    end
                end
                PORT_WAIT: begin
                    // memory takes the access at this same edge
                    if (granted) begin
                        state <= PORT_IDLE;
                        rvalid <= !cmd_we;
                    end
                end
            endcase
        end
    end

    // address and write data captured at acceptance
    // stable until the grant edge
    always_ff @(posedge clk) begin
        if (accept) begin
            cmd_addr <= addr;
            cmd_wdata <= wdata;
        end
    end

endmodule

`default_nettype wire

// File: design/shared_ram.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram
    import shared_ram_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset,
    // one-hot grant, all zero when idle
    input  client_vec_t               grant,
    // held commands of every client
    input  client_vec_t               cmd_we,
    input  addr_t [N_CLIENTS-1:0]     cmd_addr,
    input  data_t [N_CLIENTS-1:0]     cmd_wdata,
    // registered read word, shared by all clients
    output data_t                     rdata
);

    data_t mem [MEM_DEPTH];

    logic  sel_valid;
    logic  sel_we;
    addr_t sel_addr;
    data_t sel_wdata;

    // any client granted this cycle
    assign sel_valid = |grant;

    // one-hot mux as an AND-OR tree
    // at most one term is non-zero
    always_comb begin
        sel_we = 1'b0;
        sel_addr = '0;
        sel_wdata = '0;
        for (int i = 0; i < N_CLIENTS; i++) begin
            sel_we = sel_we | (grant[i] & cmd_we[i]);
            sel_addr = sel_addr | (cmd_addr[i] & {ADDR_W{grant[i]}});
            sel_wdata = sel_wdata | (cmd_wdata[i] & {DATA_W{grant[i]}});
        end
    end

    // reset clears every word and the read register
    // write lands at the grant edge
    // read word registered at the grant edge, valid with rvalid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
            rdata <= '0;
        end else if (sel_valid) begin
            if (sel_we) begin
                mem[sel_addr] <= sel_wdata;
            end else begin
                rdata <= mem[sel_addr];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/shared_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram_top
    import shared_ram_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    // per-client request levels
    input  client_vec_t           req,
    input  client_vec_t           we,
    input  client_vec_t           hold,
    input  addr_t [N_CLIENTS-1:0] addr,
    input  data_t [N_CLIENTS-1:0] wdata,
    // per-client status
    output client_vec_t           busy,
    output client_vec_t           rvalid,
    // read data for whichever client sees rvalid
    output data_t                 rdata
);

    // one bit per client port
    client_vec_t           pending;
    client_vec_t           pending_hold;
    client_vec_t           grant;
    client_vec_t           cmd_we;

    // held commands, packed per client
    addr_t [N_CLIENTS-1:0] cmd_addr;
    data_t [N_CLIENTS-1:0] cmd_wdata;

    // busy is the pending set seen from outside
    assign busy = pending;

    // one request holder per client
    for (genvar i = 0; i < N_CLIENTS; i++) begin : g_port
        client_port client_port_i (
            .clk          (clk),
            .reset        (reset),
            .req          (req[i]),
            .we           (we[i]),
            .hold         (hold[i]),
            .addr         (addr[i]),
            .wdata        (wdata[i]),
            .granted      (grant[i]),
            .busy         (pending[i]),
            .pending_hold (pending_hold[i]),
            .cmd_we       (cmd_we[i]),
            .cmd_addr     (cmd_addr[i]),
            .cmd_wdata    (cmd_wdata[i]),
            .rvalid       (rvalid[i])
        );
    end

    // round robin over pending clients
    // hold on the winner freezes the pointer
    rr_thermo_arbiter rr_thermo_arbiter_i (
        .clk     (clk),
        .reset   (reset),
        .request (pending),
        .hold    (pending_hold),
        .grant   (grant)
    );

    // single-port memory, one access per cycle
    shared_ram shared_ram_i (
        .clk       (clk),
        .reset     (reset),
        .grant     (grant),
        .cmd_we    (cmd_we),
        .cmd_addr  (cmd_addr),
        .cmd_wdata (cmd_wdata),
        .rdata     (rdata)
    );

endmodule

`default_nettype wire

// File: testbench/shared_ram_assert.sv
`timescale 1ns/1ps
`default_nettype none

module shared_ram_assert
    import shared_ram_pkg::*;
(
    input logic        clk,
    input logic        reset,
    input client_vec_t grant,
    input client_vec_t pending,
    input client_vec_t rvalid
);

    // at most one winner per cycle
    a_grant_onehot: assert property (
        @(posedge clk) disable iff (reset) $onehot0(grant)
    ) else $error("grant %b is not one-hot or zero", grant);

    // winner must have a request waiting
    a_grant_pending: assert property (
        @(posedge clk) disable iff (reset) (grant & ~pending) == '0
    ) else $error("grant %b outside pending set %b", grant, pending);

    // read completion only for last cycle's winner
    a_rvalid_granted: assert property (
        @(posedge clk) disable iff (reset) (rvalid & ~$past(grant)) == '0
    ) else $error("rvalid %b without a grant the cycle before", rvalid);

endmodule

bind shared_ram_top shared_ram_assert shared_ram_assert_i (
    .clk     (clk),
    .reset   (reset),
    .grant   (grant),
    .pending (pending),
    .rvalid  (rvalid)
);

`default_nettype wire

// File: testbench/tb_shared_ram_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_shared_ram_top
    import shared_ram_pkg::*;
();

    logic                  clk;
    logic                  reset;
    client_vec_t           req;
    client_vec_t           we;
    client_vec_t           hold;
    addr_t [N_CLIENTS-1:0] addr;
    data_t [N_CLIENTS-1:0] wdata;
    client_vec_t           busy;
    client_vec_t           rvalid;
    data_t                 rdata;

    // reference model state
    client_vec_t m_pending;
    client_vec_t m_we;
    client_vec_t m_hold;
    addr_t       m_addr [N_CLIENTS];
    data_t       m_wdata [N_CLIENTS];
    int          m_ptr;
    data_t       m_mem [MEM_DEPTH];
    client_vec_t m_rvalid;
    data_t       m_rdata;

    integer seed;
    string  test_name;
    int     value_errors;
    int     timeout_errors;

    shared_ram_top shared_ram_top_i (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .we     (we),
        .hold   (hold),
        .addr   (addr),
        .wdata  (wdata),
        .busy   (busy),
        .rvalid (rvalid),
        .rdata  (rdata)
    );

    // 8 ns period
    initial clk = 1'b0;
    always #4 clk = ~clk;

    function automatic client_vec_t onehot_of(input int c);
        client_vec_t v;
        v = '0;
        v[c] = 1'b1;
        return v;
    endfunction

    task automatic check_vec(input string name, input client_vec_t exp, input client_vec_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (exp !== act) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic model_reset();
        m_pending = '0;
        m_we = '0;
        m_hold = '0;
        m_ptr = 0;
        m_rvalid = '0;
        m_rdata = '0;
        for (int i = 0; i < MEM_DEPTH; i++) begin
            m_mem[i] = '0;
        end
    endtask

    // one rising edge of the model with inputs as sampled at that edge
    task automatic model_edge();
        int          w;
        client_vec_t was_idle;
        w = -1;
        was_idle = ~m_pending;
        // lowest pending at or above the pointer
        for (int i = N_CLIENTS - 1; i >= m_ptr; i--) begin
            if (m_pending[i]) w = i;
        end
        // otherwise lowest pending overall
        if (w < 0) begin
            for (int i = N_CLIENTS - 1; i >= 0; i--) begin
                if (m_pending[i]) w = i;
            end
        end
        m_rvalid = '0;
        if (w >= 0) begin
            if (m_we[w]) begin
                m_mem[m_addr[w]] = m_wdata[w];
            end else begin
                m_rdata = m_mem[m_addr[w]];
                m_rvalid[w] = 1'b1;
            end
            m_pending[w] = 1'b0;
            // held grant keeps the pointer where it is
            if (!m_hold[w]) m_ptr = (w + 1) % N_CLIENTS;
        end
        // acceptance only for clients idle before this edge
        for (int i = 0; i < N_CLIENTS; i++) begin
            if (was_idle[i] && req[i]) begin
                m_pending[i] = 1'b1;
                m_we[i] = we[i];
                m_hold[i] = hold[i];
                m_addr[i] = addr[i];
                m_wdata[i] = wdata[i];
            end
        end
    endtask

    // advance one cycle and compare outputs 1 ns after the edge
    task automatic step();
        @(posedge clk);
        model_edge();
        #1;
        check_vec({test_name, " busy"}, m_pending, busy);
        check_vec({test_name, " rvalid"}, m_rvalid, rvalid);
        if (|m_rvalid) check_data({test_name, " rdata"}, m_rdata, rdata);
    endtask

    task automatic clear_inputs();
        req = '0;
        we = '0;
        hold = '0;
    endtask

    task automatic set_client(input int c, input logic w, input logic h, input addr_t a,
                              input data_t d);
        req[c] = 1'b1;
        we[c] = w;
        hold[c] = h;
        addr[c] = a;
        wdata[c] = d;
    endtask

    task automatic wait_all_idle(input int limit);
        int cycles;
        cycles = 0;
        while (busy !== '0 && cycles < limit) begin
            step();
            cycles++;
        end
        if (busy !== '0) begin
            timeout_errors++;
            $display("%s: clients still busy after %0d cycles, stopped waiting", test_name, limit);
        end
    endtask

    // uncontested access granted one edge after acceptance
    task automatic single_access(input int c, input logic w, input logic h, input addr_t a,
                                 input data_t d, input data_t exp);
        client_vec_t exp_rv;
        exp_rv = w ? client_vec_t'(0) : onehot_of(c);
        set_client(c, w, h, a, d);
        step();
        clear_inputs();
        step();
        check_vec({test_name, " busy after grant"}, '0, busy);
        check_vec({test_name, " rvalid pulse"}, exp_rv, rvalid);
        if (!w) check_data({test_name, " read word"}, exp, rdata);
        step();
        check_vec({test_name, " rvalid drop"}, '0, rvalid);
    endtask

    initial begin
        logic [31:0] rnd;
        addr_t       a;
        data_t       d;
        int          start;
        int          c;
        int          x;
        int          last;
        int          cycles;

        seed = 32'h14c82703;
        value_errors = 0;
        timeout_errors = 0;
        reset = 1'b1;
        req = '0;
        we = '0;
        hold = '0;
        addr = '0;
        wdata = '0;
        test_name = "reset";
        model_reset();
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        // cleared state and cleared memory
        check_vec("reset busy", '0, busy);
        check_vec("reset rvalid", '0, rvalid);
        check_data("reset rdata", '0, rdata);
        for (int k = 0; k < 8; k++) begin
            rnd = $random(seed);
            single_access(k % N_CLIENTS, 1'b0, 1'b0, rnd[ADDR_W-1:0], '0, '0);
        end

        // write then read back through another client
        test_name = "single";
        for (int k = 0; k < N_CLIENTS; k++) begin
            rnd = $random(seed);
            a = rnd[ADDR_W-1:0];
            rnd = $random(seed);
            d = rnd[DATA_W-1:0];
            single_access(k, 1'b1, 1'b0, a, d, '0);
            single_access((k + 1) % N_CLIENTS, 1'b0, 1'b0, a, '0, d);
        end

        // all four read at once and rvalid pulses one per cycle from the pointer
        test_name = "fairness";
        for (int r = 0; r < N_CLIENTS; r++) begin
            rnd = $random(seed);
            single_access(r, 1'b1, 1'b0, rnd[ADDR_W-1:0], rnd[31:32-DATA_W], '0);
            start = m_ptr;
            for (int i = 0; i < N_CLIENTS; i++) begin
                rnd = $random(seed);
                set_client(i, 1'b0, 1'b0, rnd[ADDR_W-1:0], '0);
            end
            step();
            clear_inputs();
            for (int k = 0; k < N_CLIENTS; k++) begin
                step();
                check_vec("fairness order", onehot_of((start + k) % N_CLIENTS), rvalid);
            end
            wait_all_idle(8);
        end

        // held grants leave the pointer on client c
        test_name = "hold";
        c = m_ptr;
        x = (c + 1) % N_CLIENTS;
        for (int k = 0; k < 3; k++) begin
            rnd = $random(seed);
            a = rnd[ADDR_W-1:0];
            single_access(c, 1'b0, 1'b1, a, '0, m_mem[a]);
        end
        set_client(c, 1'b0, 1'b1, a, '0);
        set_client(x, 1'b0, 1'b0, a, '0);
        step();
        clear_inputs();
        step();
        check_vec("hold keeps first place", onehot_of(c), rvalid);
        step();
        check_vec("hold other client next", onehot_of(x), rvalid);
        // without hold the pointer passes c
        single_access(c, 1'b0, 1'b0, a, '0, m_mem[a]);
        set_client(c, 1'b0, 1'b0, a, '0);
        set_client(x, 1'b0, 1'b0, a, '0);
        step();
        clear_inputs();
        step();
        check_vec("released hold lets other first", onehot_of(x), rvalid);
        step();
        check_vec("released hold client after", onehot_of(c), rvalid);
        // c asks again at once with the others pending at the start
        // the others return just as c re-requests after its first held grant
        for (int k = 0; k < 10; k++) begin
            for (int i = 0; i < N_CLIENTS; i++) begin
                rnd = $random(seed);
                if (i == c) set_client(i, 1'b0, k < 6, rnd[ADDR_W-1:0], '0);
                else if (k == 0 || k == 5) set_client(i, 1'b0, 1'b0, rnd[ADDR_W-1:0], '0);
                else req[i] = 1'b0;
            end
            step();
        end
        clear_inputs();
        wait_all_idle(16);

        // requests while busy must be dropped
        test_name = "backpressure";
        rnd = $random(seed);
        a = rnd[ADDR_W-1:0];
        d = rnd[31:32-DATA_W];
        single_access(0, 1'b1, 1'b0, a, d, '0);
        last = (m_ptr + N_CLIENTS - 1) % N_CLIENTS;
        for (int i = 0; i < N_CLIENTS; i++) begin
            set_client(i, 1'b0, 1'b0, a, '0);
        end
        step();
        clear_inputs();
        cycles = 0;
        // would overwrite the word if it got through
        while (busy[last] && cycles < 10) begin
            set_client(last, 1'b1, 1'b0, a, ~d);
            step();
            cycles++;
        end
        clear_inputs();
        if (busy[last]) begin
            timeout_errors++;
            $display("backpressure: client %0d never left busy", last);
        end
        step();
        check_vec("no extra access busy", '0, busy);
        check_vec("no extra rvalid", '0, rvalid);
        single_access(last, 1'b0, 1'b0, a, '0, d);

        // seeded random traffic on every port
        test_name = "random";
        for (int k = 0; k < 2000; k++) begin
            for (int i = 0; i < N_CLIENTS; i++) begin
                rnd = $random(seed);
                req[i] = rnd[0] | rnd[1];
                we[i] = rnd[2];
                hold[i] = rnd[3] & rnd[4];
                addr[i] = rnd[ADDR_W+7:8];
                wdata[i] = rnd[31:32-DATA_W];
            end
            step();
        end
        clear_inputs();
        wait_all_idle(16);

        $display("errors: %0d value mismatches, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
design/shared_ram_pkg.sv
design/rr_thermo_arbiter.sv
design/client_port.sv
design/shared_ram.sv
design/shared_ram_top.sv
testbench/shared_ram_assert.sv
testbench/tb_shared_ram_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the shared RAM testbench with Verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_shared_ram_top \
    -f files.f

# the log decides the result, a stopped simulation is caught below
./obj_dir/Vtb_shared_ram_top > "$LOG" 2>&1 || true
cat "$LOG"

if grep -q "Simulation failed" "$LOG" || grep -q "%Error" "$LOG"; then
    echo "run_sim: failures reported, see $LOG"
    exit 1
fi
if ! grep -q "Simulation passed" "$LOG"; then
    echo "run_sim: simulation ended without a result, see $LOG"
    exit 1
fi
echo "run_sim: done"
